/* dac_palette_ram.sv */
// Palette RAM with a CPU read/write port and a read-only pixel port
`timescale 1ns/1ps
`include "video_cfg.svh"

module dac_palette_ram (
    input  logic                     clk,

    // CPU side
    input  logic [`VIDEO_DAC_AW-1:0] a_addr,
    input  logic [`VIDEO_RGB_W-1:0]  a_wdata,
    input  logic                     a_we,
    output logic [`VIDEO_RGB_W-1:0]  a_rdata,

    // Pixel side
    input  logic [`VIDEO_DAC_AW-1:0] b_addr,
    input  logic                     b_en,
    output logic [`VIDEO_RGB_W-1:0]  b_rdata
);
    logic [`VIDEO_RGB_W-1:0] mem [`VIDEO_DAC_DEPTH];

    // Read-first, a write returns the old entry
    always_ff @(posedge clk) begin
        if (a_we)
            mem[a_addr] <= a_wdata;
        a_rdata <= mem[a_addr];
    end

    // Output holds while the lookup stage is stalled
    always_ff @(posedge clk) begin
        if (b_en)
            b_rdata <= mem[b_addr];
    end

endmodule

/* files.f */
+incdir+.
video_bus_pkg.sv
video_pixel_pkg.sv
video_registers.sv
dac_palette_ram.sv
pipe_stage.sv
palette_lookup.sv
video_subsystem.sv
video_assertions.sv
tb_video_subsystem.sv

/* palette_lookup.sv */
// Pixel lookup stage mapping a colour index to a DAC address and returning its RGB
`timescale 1ns/1ps
`include "video_cfg.svh"

module palette_lookup (
    input  logic                          clk,
    input  logic                          reset,
    input  video_pixel_pkg::palette_ctl_t palette_ctl,

    // Pixel index stream
    input  logic                          in_valid,
    output logic                          in_ready,
    input  video_pixel_pkg::pixel_in_t    in_data,

    // Resolved colour stream
    output logic                          out_valid,
    input  logic                          out_ready,
    output video_pixel_pkg::pixel_out_t   out_data,

    // Palette RAM pixel port
    output logic [`VIDEO_DAC_AW-1:0]      ram_addr,
    output logic                          ram_en,
    input  logic [`VIDEO_RGB_W-1:0]       ram_rdata
);
    localparam int AW = `VIDEO_DAC_AW;

    logic [3:0] nibble;
    logic       eol_q;

    // Only one result in flight, read only when it has room to move
    assign in_ready = !out_valid || out_ready;
    assign ram_en   = in_valid && in_ready;

    // Colour zero shows the background in 16-colour modes
    assign nibble = (in_data.index[3:0] == 4'h0) ? palette_ctl.background
                                                 : in_data.index[3:0];

    always_comb begin
        if (palette_ctl.color_256)
            ram_addr = in_data.index;
        else
            ram_addr = {{(AW-6){1'b0}}, palette_ctl.palette_sel,
                        palette_ctl.bright_colors, nibble};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            out_valid <= 1'b0;
        else if (ram_en)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // End-of-line flag travels beside the RAM read
    always_ff @(posedge clk) begin
        if (ram_en)
            eol_q <= in_data.eol;
    end

    assign out_data = '{rgb: ram_rdata, eol: eol_q};

endmodule

/* pipe_stage.sv */
// One-entry valid/ready register stage for any packed payload
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,

    // Upstream
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Downstream
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    logic take_in;

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign take_in  = in_valid && in_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            out_valid <= 1'b0;
        else if (take_in)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take_in)
            out_data <= in_data;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the adapter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_video_subsystem -f files.f

output=$(./obj_dir/Vtb_video_subsystem) || true
printf '%s\n' "$output"

# Only the pass line counts as success
printf '%s\n' "$output" | grep -qx "Everything OK"

/* tb_video_subsystem.sv */
// Testbench for the display adapter covering registers, DAC sequencing, mode detection and pixels
`timescale 1ns/1ps
`include "video_cfg.svh"

module tb_video_subsystem;
    import video_bus_pkg::*;
    import video_pixel_pkg::*;

    localparam int DEPTH = `VIDEO_DAC_DEPTH;
    localparam int PIX_N = 48;
    localparam int N_CFG = 6;
    localparam int ACK_WAIT = 8;
    // One step is a bus access or a pixel, each given 200 cycles
    localparam int STEPS = 7 * DEPTH + N_CFG * (PIX_N + 4) + 100;
    localparam longint TIMEOUT_NS = longint'(STEPS) * 200 * 10 + 5000;

    logic        clk = 1'b0;
    logic        reset;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    cursor_cfg_t cursor_cfg;
    mode_num_t   mode_num;
    logic        pix_in_valid;
    logic        pix_in_ready;
    pixel_in_t   pix_in;
    logic        pix_out_valid;
    logic        pix_out_ready;
    pixel_out_t  pix_out;

    // Reference palette and stream bookkeeping
    logic [`VIDEO_RGB_W-1:0] ref_pal [DEPTH];
    logic [31:0]             lcg_state = 32'd65052;
    pixel_in_t               stim_q[$];
    pixel_out_t              exp_q[$];
    int                      in_cyc_q[$];
    int cyc = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    video_subsystem DUT (
        .clk           (clk),
        .reset         (reset),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .cursor_cfg    (cursor_cfg),
        .mode_num      (mode_num),
        .pix_in_valid  (pix_in_valid),
        .pix_in_ready  (pix_in_ready),
        .pix_in        (pix_in),
        .pix_out_valid (pix_out_valid),
        .pix_out_ready (pix_out_ready),
        .pix_out       (pix_out)
    );

    bind video_subsystem video_assertions u_protocol_checks (
        .clk           (clk),
        .reset         (reset),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .pix_in_valid  (pix_in_valid),
        .pix_in_ready  (pix_in_ready),
        .pix_in        (pix_in),
        .pix_out_valid (pix_out_valid),
        .pix_out_ready (pix_out_ready),
        .pix_out       (pix_out)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {8'h00, lcg_state[31:8]};
    endfunction

    // 13h wins over everything and 04h needs graphics without text
    function automatic mode_num_t expected_mode(input logic [7:0] mode_val,
                                                input logic [7:0] amcr_val);
        if (amcr_val == 8'h41)
            return MODE_13H;
        if (mode_val[1] && !mode_val[0])
            return MODE_04H;
        return MODE_03H;
    endfunction

    // csel holds palette select, bright and background as in the colour select register
    function automatic logic [7:0] palette_address(input logic is_256, input logic [5:0] csel,
                                                   input logic [7:0] index);
        logic [3:0] nib;
        if (is_256)
            return index;
        nib = (index[3:0] == 4'h0) ? csel[3:0] : index[3:0];
        return {2'b00, csel[5:4], nib};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // Single access, then wait for the registered ack
    task automatic bus_access(input logic [3:0] offs, input logic [1:0] sel, input logic we,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int wait_cycles = 0;
        @(posedge clk);
        bus_req <= '{offset: offs, wdata: wdata, bytesel: sel, we: we, access: 1'b1};
        @(posedge clk);
        bus_req <= '0;
        @(negedge clk);
        while (!bus_rsp.ack && wait_cycles < ACK_WAIT) begin
            wait_cycles++;
            @(negedge clk);
        end
        assert (bus_rsp.ack) else begin
            errors++;
            $display("No bus ack at time %0t for offset %0h", $time, offs);
        end
        rdata = bus_rsp.rdata;
    endtask

    task automatic write_reg(input logic [3:0] offs, input logic [1:0] sel,
                             input logic [15:0] wdata);
        logic [15:0] unused;
        bus_access(offs, sel, 1'b1, wdata, unused);
    endtask

    task automatic read_reg(input logic [3:0] offs, input logic [1:0] sel,
                            output logic [15:0] rdata);
        bus_access(offs, sel, 1'b0, 16'h0000, rdata);
    endtask

    task automatic test_reset_state();
        int err0 = errors;
        logic [15:0] v;
        check_value("ack after reset", bus_rsp.ack, 0);
        check_value("pix_out_valid after reset", pix_out_valid, 0);
        check_value("mode_num after reset", mode_num, MODE_03H);
        check_value("cursor enable after reset", cursor_cfg.enable, 1);
        read_reg(`REG_AMCR, 2'b01, v);
        check_value("AMCR", v, 16'h0000);
        // Text and display enabled with graphics off
        read_reg(`REG_MODE, 2'b01, v);
        check_value("mode register", v, 16'h0009);
        read_reg(`REG_MODE, 2'b10, v);
        check_value("colour select", v, 16'h0000);
        read_reg(`REG_CRT, 2'b11, v);
        check_value("CRT index and data", v, 16'h0000);
        read_reg(`REG_DAC_RD_IDX, 2'b10, v);
        check_value("DAC read index", v, 16'h0000);
        read_reg(`REG_DAC, 2'b01, v);
        check_value("DAC write index", v, 16'h0000);
        finish_test("reset state", err0);
    endtask

    task automatic test_crt_registers();
        int err0 = errors;
        logic [15:0] v;
        logic [3:0] idx [4] = '{4'hA, 4'hB, 4'hE, 4'hF};
        logic [7:0] wval [4] = '{8'h2D, 8'h0E, 8'hCA, 8'h5C};
        // Bits each CRT register keeps
        logic [7:0] mask [4] = '{8'h37, 8'h07, 8'h7F, 8'hFF};
        for (int k = 0; k < 4; k++) begin
            write_reg(`REG_CRT, 2'b01, {12'h000, idx[k]});
            write_reg(`REG_CRT, 2'b10, {wval[k], 8'h00});
        end
        for (int k = 0; k < 4; k++) begin
            write_reg(`REG_CRT, 2'b01, {12'h000, idx[k]});
            read_reg(`REG_CRT, 2'b10, v);
            check_value($sformatf("CRT register %0h", idx[k]), v[15:8], wval[k] & mask[k]);
        end
        check_value("cursor enable, mode 2", cursor_cfg.enable, 1);
        check_value("cursor position", cursor_cfg.pos, 15'h4A5C);
        check_value("cursor scan start", cursor_cfg.scan_start, 3'd5);
        check_value("cursor scan end", cursor_cfg.scan_end, 3'd6);
        // Cursor mode 1 hides the cursor
        write_reg(`REG_CRT, 2'b11, {8'h13, 8'h0A});
        check_value("cursor enable, mode 1", cursor_cfg.enable, 0);
        check_value("cursor scan start", cursor_cfg.scan_start, 3'd3);
        write_reg(`REG_CRT, 2'b11, {8'h00, 8'h0A});
        check_value("cursor enable, mode 0", cursor_cfg.enable, 1);
        finish_test("CRT registers", err0);
    endtask

    task automatic test_dac_sequencing();
        int err0 = errors;
        logic [15:0] v;
        logic [31:0] r;
        logic [5:0]  comp;
        write_reg(`REG_DAC, 2'b01, 16'h0000);
        for (int i = 0; i < DEPTH; i++) begin
            r = next_random();
            ref_pal[i] = r[17:0];
            write_reg(`REG_DAC, 2'b10, {2'b00, r[17:12], 8'h00});
            write_reg(`REG_DAC, 2'b10, {2'b00, r[11:6], 8'h00});
            write_reg(`REG_DAC, 2'b10, {2'b00, r[5:0], 8'h00});
        end
        // 256 entries wrap the write index round to 0
        read_reg(`REG_DAC, 2'b01, v);
        check_value("DAC write index after full load", v, 16'h0000);
        // Write index moves on only after the blue component
        write_reg(`REG_DAC, 2'b01, 16'h0037);
        for (int c = 0; c < 3; c++) begin
            comp = ref_pal[55][(2 - c) * 6 +: 6];
            write_reg(`REG_DAC, 2'b10, {2'b00, comp, 8'h00});
            read_reg(`REG_DAC, 2'b01, v);
            check_value($sformatf("DAC write index after component %0d", c), v,
                        (c == 2) ? 16'h0038 : 16'h0037);
        end
        write_reg(`REG_DAC_RD_IDX, 2'b10, 16'h0000);
        for (int i = 0; i < DEPTH; i++) begin
            for (int c = 0; c < 3; c++) begin
                comp = ref_pal[i][(2 - c) * 6 +: 6];
                read_reg(`REG_DAC, 2'b10, v);
                check_value($sformatf("DAC entry %0d component %0d", i, c), v,
                            {2'b00, comp, 8'h00});
            end
        end
        read_reg(`REG_DAC_RD_IDX, 2'b10, v);
        check_value("DAC read index after full pass", v, 16'h0000);
        write_reg(`REG_DAC_RD_IDX, 2'b10, 16'hC800);
        for (int c = 0; c < 3; c++) begin
            comp = ref_pal[200][(2 - c) * 6 +: 6];
            read_reg(`REG_DAC, 2'b10, v);
            check_value($sformatf("DAC entry 200 component %0d", c), v, {2'b00, comp, 8'h00});
        end
        read_reg(`REG_DAC_RD_IDX, 2'b10, v);
        check_value("DAC read index step", v, 16'hC900);
        finish_test("DAC sequencing", err0);
    endtask

    task automatic test_mode_detection();
        int err0 = errors;
        logic [15:0] v;
        logic [7:0] modes [7] = '{8'h09, 8'h0A, 8'h0B, 8'h08, 8'h0A, 8'h09, 8'h02};
        logic [7:0] amcrs [7] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h41, 8'h40, 8'h00};
        for (int k = 0; k < 7; k++) begin
            write_reg(`REG_MODE, 2'b01, {8'h00, modes[k]});
            write_reg(`REG_AMCR, 2'b01, {8'h00, amcrs[k]});
            check_value($sformatf("mode_num for mode %0h AMCR %0h", modes[k], amcrs[k]),
                        mode_num, expected_mode(modes[k], amcrs[k]));
            read_reg(`REG_MODE, 2'b01, v);
            check_value("mode register readback", v, {8'h00, modes[k] & 8'h0B});
        end
        finish_test("mode detection", err0);
    endtask

    task automatic drive_pixels(input logic is_256, input logic [5:0] csel);
        pixel_in_t  p;
        pixel_out_t exp;
        while (stim_q.size() > 0) begin
            p = stim_q.pop_front();
            @(posedge clk);
            pix_in_valid <= 1'b1;
            pix_in <= p;
            @(negedge clk);
            while (!pix_in_ready)
                @(negedge clk);
            // Accepted on the coming edge
            exp.rgb = ref_pal[palette_address(is_256, csel, p.index)];
            exp.eol = p.eol;
            exp_q.push_back(exp);
            in_cyc_q.push_back(cyc);
        end
        @(posedge clk);
        pix_in_valid <= 1'b0;
    endtask

    task automatic collect_pixels(input logic random_ready);
        logic [31:0] r;
        pixel_out_t  exp;
        int in_cyc;
        int got = 0;
        while (got < PIX_N) begin
            r = next_random();
            @(posedge clk);
            pix_out_ready <= random_ready ? (r[0] | r[1]) : 1'b1;
            @(negedge clk);
            if (pix_out_valid && pix_out_ready) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("Output pixel at time %0t with no pixel outstanding", $time);
                end
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    in_cyc = in_cyc_q.pop_front();
                    check_value($sformatf("pixel %0d rgb", got), pix_out.rgb, exp.rgb);
                    check_value($sformatf("pixel %0d eol", got), pix_out.eol, exp.eol);
                    if (!random_ready)
                        check_value("pixel latency", cyc - in_cyc, 2);
                end
                got++;
            end
        end
        @(posedge clk);
        pix_out_ready <= 1'b1;
    endtask

    task automatic test_pixel_path();
        int err0 = errors;
        logic [31:0] r;
        logic       cfg_256  [N_CFG] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
        logic [5:0] cfg_csel [N_CFG] = '{6'h00, 6'h15, 6'h00, 6'h2B, 6'h17, 6'h3F};
        logic       cfg_rand [N_CFG] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
        for (int k = 0; k < N_CFG; k++) begin
            write_reg(`REG_AMCR, 2'b01, cfg_256[k] ? 16'h0041 : 16'h0000);
            write_reg(`REG_MODE, 2'b10, {2'b00, cfg_csel[k], 8'h00});
            stim_q.delete();
            exp_q.delete();
            in_cyc_q.delete();
            for (int i = 0; i < PIX_N; i++) begin
                r = next_random();
                stim_q.push_back('{index: r[7:0], eol: r[8]});
            end
            fork
                drive_pixels(cfg_256[k], cfg_csel[k]);
                collect_pixels(cfg_rand[k]);
            join
            repeat (3) @(negedge clk);
            check_value($sformatf("extra output pixel, setting %0d", k), pix_out_valid, 0);
            check_value("pixels still expected", exp_q.size(), 0);
        end
        finish_test("pixel path", err0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at time %0t before the tests finished", $time);
        $display("Something failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        bus_req = '0;
        pix_in_valid = 1'b0;
        pix_in = '0;
        pix_out_ready = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_reset_state();
        test_crt_registers();
        test_dac_sequencing();
        test_mode_detection();
        test_pixel_path();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* video_assertions.sv */
// Protocol checks on the adapter bus ack and the pixel stream handshakes
`timescale 1ns/1ps

module video_assertions (
    input logic                        clk,
    input logic                        reset,
    input video_bus_pkg::bus_req_t     bus_req,
    input video_bus_pkg::bus_rsp_t     bus_rsp,
    input logic                        pix_in_valid,
    input logic                        pix_in_ready,
    input video_pixel_pkg::pixel_in_t  pix_in,
    input logic                        pix_out_valid,
    input logic                        pix_out_ready,
    input video_pixel_pkg::pixel_out_t pix_out
);

    // Ack answers every access exactly one cycle later
    ack_follows_access: assert property (@(posedge clk) disable iff (reset)
        bus_req.access |=> bus_rsp.ack)
        else $error("bus access not acknowledged on the next cycle");

    ack_needs_access: assert property (@(posedge clk) disable iff (reset)
        !bus_req.access |=> !bus_rsp.ack)
        else $error("bus ack without an access on the cycle before");

    // A waiting pixel keeps its valid and payload
    pix_in_held: assert property (@(posedge clk) disable iff (reset)
        pix_in_valid && !pix_in_ready |=> pix_in_valid && $stable(pix_in))
        else $error("pix_in dropped or changed while stalled");

    pix_out_held: assert property (@(posedge clk) disable iff (reset)
        pix_out_valid && !pix_out_ready |=> pix_out_valid && $stable(pix_out))
        else $error("pix_out dropped or changed while stalled");

endmodule

/* video_bus_pkg.sv */
// CPU bus cycle types and register field layouts of the display adapter
`include "video_cfg.svh"

package video_bus_pkg;

    // One bus cycle, access is a single-cycle strobe
    typedef struct packed {
        logic [`VIDEO_OFFS_W-1:0]    offset;
        logic [`VIDEO_BUS_W-1:0]     wdata;
        logic [`VIDEO_BUS_SEL_W-1:0] bytesel;
        logic                        we;
        logic                        access;
    } bus_req_t;

    typedef struct packed {
        logic [`VIDEO_BUS_W-1:0] rdata;
        logic                    ack;
    } bus_rsp_t;

    typedef struct packed {
        logic        enable;
        logic [14:0] pos;
        logic [2:0]  scan_start;
        logic [2:0]  scan_end;
    } cursor_cfg_t;

    // Mode control, kept from bits 3, 1 and 0 of the low byte
    typedef struct packed {
        logic display_enabled;
        logic graphics_enabled;
        logic text_enabled;
    } mode_reg_t;

    // Colour select, bits 5 to 0 of the high byte
    typedef struct packed {
        logic       palette_sel;
        logic       bright_colors;
        logic [3:0] background;
    } color_sel_t;

endpackage

/* video_cfg.svh */
// Display adapter build constants for palette size, data widths and register map
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// Palette geometry
`define VIDEO_DAC_DEPTH 256
`define VIDEO_DAC_AW    $clog2(`VIDEO_DAC_DEPTH)

// One DAC component is 6 bits, an entry holds red, green and blue
`define VIDEO_COMP_W    6
`define VIDEO_RGB_W     (3 * `VIDEO_COMP_W)

// CPU bus
`define VIDEO_BUS_W     16
`define VIDEO_BUS_SEL_W (`VIDEO_BUS_W / 8)
`define VIDEO_OFFS_W    4

// Register word offsets
`define REG_AMCR        4'h0
`define REG_DAC_RD_IDX  4'h3
`define REG_DAC         4'h4
`define REG_CRT         4'hA
`define REG_MODE        4'hC

`endif

/* video_pixel_pkg.sv */
// Pixel stream, palette control and video mode types of the display adapter
`include "video_cfg.svh"

package video_pixel_pkg;

    // BIOS mode numbers reported by mode detection
    typedef enum logic [7:0] {
        MODE_03H = 8'h03,
        MODE_04H = 8'h04,
        MODE_13H = 8'h13
    } mode_num_t;

    // Settings the lookup stage needs to form a DAC address
    typedef struct packed {
        logic       color_256;
        logic       palette_sel;
        logic       bright_colors;
        logic [3:0] background;
    } palette_ctl_t;

    // Colour index from the renderer
    typedef struct packed {
        logic [`VIDEO_DAC_AW-1:0] index;
        logic                     eol;
    } pixel_in_t;

    // Resolved colour, red in the top component
    typedef struct packed {
        logic [`VIDEO_RGB_W-1:0] rgb;
        logic                    eol;
    } pixel_out_t;

endpackage

/* video_registers.sv */
// Adapter register file with CRT cursor registers, mode and colour select, AMCR and DAC port
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_registers (
    input  logic                          clk,
    input  logic                          reset,
    input  video_bus_pkg::bus_req_t       bus_req,
    output video_bus_pkg::bus_rsp_t       bus_rsp,
    output logic [`VIDEO_DAC_AW-1:0]      dac_addr,
    output logic [`VIDEO_RGB_W-1:0]       dac_wdata,
    output logic                          dac_we,
    input  logic [`VIDEO_RGB_W-1:0]       dac_rdata,
    output video_pixel_pkg::palette_ctl_t palette_ctl,
    output video_bus_pkg::cursor_cfg_t    cursor_cfg,
    output video_pixel_pkg::mode_num_t    mode_num
);
    import video_bus_pkg::*;
    import video_pixel_pkg::*;

    localparam int CW = `VIDEO_COMP_W;
    localparam logic [7:0] AMCR_256_COLOR = 8'h41;

    logic        wr;
    logic        rd;
    logic [7:0]  wr_lo;
    logic [7:0]  wr_hi;
    logic        sel_amcr;
    logic        sel_dac_rd_idx;
    logic        sel_dac_wr_idx;
    logic        sel_dac;
    logic        sel_crt_idx;
    logic        sel_crt_data;
    logic        sel_mode;
    logic        sel_color;

    logic [3:0]  crt_index;
    logic [3:0]  crt_sel_index;
    logic [7:0]  crt_value;
    logic [1:0]  cursor_mode;
    logic [2:0]  scan_start;
    logic [2:0]  scan_end;
    logic [14:0] cursor_pos;
    mode_reg_t   mode_reg;
    color_sel_t  color_sel;
    logic [7:0]  amcr;
    logic        is_256_color;

    logic [7:0]      dac_wr_idx;
    logic [7:0]      dac_rd_idx;
    logic [1:0]      dac_wr_offs;
    logic [1:0]      dac_rd_offs;
    logic [2*CW-1:0] dac_rg;
    logic [15:0]     rdata_next;

    assign wr    = bus_req.access & bus_req.we;
    assign rd    = bus_req.access & ~bus_req.we;
    assign wr_lo = bus_req.wdata[7:0];
    assign wr_hi = bus_req.wdata[15:8];

    // Each register sits on one byte lane of its word
    assign sel_amcr       = bus_req.offset == `REG_AMCR && bus_req.bytesel[0];
    assign sel_dac_rd_idx = bus_req.offset == `REG_DAC_RD_IDX && bus_req.bytesel[1];
    assign sel_dac_wr_idx = bus_req.offset == `REG_DAC && bus_req.bytesel[0];
    assign sel_dac        = bus_req.offset == `REG_DAC && bus_req.bytesel[1];
    assign sel_crt_idx    = bus_req.offset == `REG_CRT && bus_req.bytesel[0];
    assign sel_crt_data   = bus_req.offset == `REG_CRT && bus_req.bytesel[1];
    assign sel_mode       = bus_req.offset == `REG_MODE && bus_req.bytesel[0];
    assign sel_color      = bus_req.offset == `REG_MODE && bus_req.bytesel[1];

    // A word write may set the CRT index and its data together
    assign crt_sel_index = (wr && sel_crt_idx) ? wr_lo[3:0] : crt_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crt_index   <= '0;
            cursor_mode <= '0;
            scan_start  <= '0;
            scan_end    <= '0;
            cursor_pos  <= '0;
            mode_reg    <= '{display_enabled: 1'b1, graphics_enabled: 1'b0, text_enabled: 1'b1};
            color_sel   <= '0;
            amcr        <= '0;
        end else begin
            if (wr && sel_crt_idx)
                crt_index <= wr_lo[3:0];
            if (wr && sel_crt_data) begin
                case (crt_sel_index)
                    4'ha: {cursor_mode, scan_start} <= {wr_hi[5:4], wr_hi[2:0]};
                    4'hb: scan_end <= wr_hi[2:0];
                    4'he: cursor_pos[14:8] <= wr_hi[6:0];
                    4'hf: cursor_pos[7:0] <= wr_hi;
                    default: ;
                endcase
            end
            if (wr && sel_mode)
                mode_reg <= {wr_lo[3], wr_lo[1], wr_lo[0]};
            if (wr && sel_color)
                color_sel <= wr_hi[5:0];
            if (wr && sel_amcr)
                amcr <= wr_lo;
        end
    end

    // DAC index and component sequencing, three accesses per entry
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dac_wr_idx  <= '0;
            dac_rd_idx  <= '0;
            dac_wr_offs <= '0;
            dac_rd_offs <= '0;
        end else begin
            if (wr && sel_dac_rd_idx) begin
                dac_rd_idx  <= wr_hi;
                dac_rd_offs <= '0;
            end
            if (wr && sel_dac_wr_idx) begin
                dac_wr_idx  <= wr_lo;
                dac_wr_offs <= '0;
            end
            if (wr && sel_dac) begin
                if (dac_wr_offs == 2'd2) begin
                    dac_wr_idx  <= dac_wr_idx + 1'b1;
                    dac_wr_offs <= '0;
                end else begin
                    dac_wr_offs <= dac_wr_offs + 1'b1;
                end
            end
            if (rd && sel_dac) begin
                if (dac_rd_offs == 2'd2) begin
                    dac_rd_idx  <= dac_rd_idx + 1'b1;
                    dac_rd_offs <= '0;
                end else begin
                    dac_rd_offs <= dac_rd_offs + 1'b1;
                end
            end
        end
    end

    // Red then green collect here until blue arrives
    always_ff @(posedge clk) begin
        if (wr && sel_dac && dac_wr_offs != 2'd2)
            dac_rg <= {dac_rg[CW-1:0], wr_hi[CW-1:0]};
    end

    assign dac_we    = wr && sel_dac && dac_wr_offs == 2'd2;
    assign dac_addr  = dac_we ? dac_wr_idx : dac_rd_idx;
    assign dac_wdata = {dac_rg, wr_hi[CW-1:0]};

    always_comb begin
        case (crt_sel_index)
            4'ha: crt_value = {2'b0, cursor_mode, 1'b0, scan_start};
            4'hb: crt_value = {5'b0, scan_end};
            4'he: crt_value = {1'b0, cursor_pos[14:8]};
            4'hf: crt_value = cursor_pos[7:0];
            default: crt_value = '0;
        endcase
    end

    always_comb begin
        rdata_next = '0;
        if (rd) begin
            if (sel_amcr)
                rdata_next[7:0] = amcr;
            if (sel_dac_rd_idx)
                rdata_next[15:8] = dac_rd_idx;
            if (sel_dac_wr_idx)
                rdata_next[7:0] = dac_wr_idx;
            if (sel_dac) begin
                // RAM output already holds the entry at the read index
                case (dac_rd_offs)
                    2'd0: rdata_next[15:8] = {{(8-CW){1'b0}}, dac_rdata[3*CW-1:2*CW]};
                    2'd1: rdata_next[15:8] = {{(8-CW){1'b0}}, dac_rdata[2*CW-1:CW]};
                    default: rdata_next[15:8] = {{(8-CW){1'b0}}, dac_rdata[CW-1:0]};
                endcase
            end
            if (sel_crt_idx)
                rdata_next[7:0] = {4'b0, crt_index};
            if (sel_crt_data)
                rdata_next[15:8] = crt_value;
            if (sel_mode)
                rdata_next[7:0] = {4'b0, mode_reg.display_enabled, 1'b0,
                                   mode_reg.graphics_enabled, mode_reg.text_enabled};
            if (sel_color)
                rdata_next[15:8] = {2'b0, color_sel};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bus_rsp <= '0;
        end else begin
            bus_rsp.rdata <= rdata_next;
            bus_rsp.ack   <= bus_req.access;
        end
    end

    assign is_256_color = amcr == AMCR_256_COLOR;

    assign palette_ctl = '{color_256:     is_256_color,
                           palette_sel:   color_sel.palette_sel,
                           bright_colors: color_sel.bright_colors,
                           background:    color_sel.background};

    // Cursor mode 1 is the only setting that hides it
    assign cursor_cfg = '{enable:     cursor_mode != 2'b01,
                          pos:        cursor_pos,
                          scan_start: scan_start,
                          scan_end:   scan_end};

    always_comb begin
        if (is_256_color)
            mode_num = MODE_13H;
        else if (mode_reg.graphics_enabled && !mode_reg.text_enabled)
            mode_num = MODE_04H;
        else
            mode_num = MODE_03H;
    end

endmodule

/* video_subsystem.sv */
// Display adapter top joining register file, palette RAM and pixel pipeline
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_subsystem (
    input  logic                        clk,
    input  logic                        reset,

    // CPU bus
    input  video_bus_pkg::bus_req_t     bus_req,
    output video_bus_pkg::bus_rsp_t     bus_rsp,

    // Configuration for the renderer
    output video_bus_pkg::cursor_cfg_t  cursor_cfg,
    output video_pixel_pkg::mode_num_t  mode_num,

    // Pixel streams
    input  logic                        pix_in_valid,
    output logic                        pix_in_ready,
    input  video_pixel_pkg::pixel_in_t  pix_in,
    output logic                        pix_out_valid,
    input  logic                        pix_out_ready,
    output video_pixel_pkg::pixel_out_t pix_out
);
    import video_pixel_pkg::*;

    logic [`VIDEO_DAC_AW-1:0] dac_addr;
    logic [`VIDEO_RGB_W-1:0]  dac_wdata;
    logic                     dac_we;
    logic [`VIDEO_RGB_W-1:0]  dac_rdata;
    palette_ctl_t             palette_ctl;

    logic                     stage_valid;
    logic                     stage_ready;
    pixel_in_t                stage_data;
    logic [`VIDEO_DAC_AW-1:0] pix_ram_addr;
    logic                     pix_ram_en;
    logic [`VIDEO_RGB_W-1:0]  pix_ram_rdata;

    video_registers u_regs (
        .clk         (clk),
        .reset       (reset),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .dac_addr    (dac_addr),
        .dac_wdata   (dac_wdata),
        .dac_we      (dac_we),
        .dac_rdata   (dac_rdata),
        .palette_ctl (palette_ctl),
        .cursor_cfg  (cursor_cfg),
        .mode_num    (mode_num)
    );

    dac_palette_ram u_palette (
        .clk     (clk),
        .a_addr  (dac_addr),
        .a_wdata (dac_wdata),
        .a_we    (dac_we),
        .a_rdata (dac_rdata),
        .b_addr  (pix_ram_addr),
        .b_en    (pix_ram_en),
        .b_rdata (pix_ram_rdata)
    );

    // Input register in front of the lookup
    pipe_stage #(
        .payload_t (pixel_in_t)
    ) u_in_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pix_in_valid),
        .in_ready  (pix_in_ready),
        .in_data   (pix_in),
        .out_valid (stage_valid),
        .out_ready (stage_ready),
        .out_data  (stage_data)
    );

    palette_lookup u_lookup (
        .clk         (clk),
        .reset       (reset),
        .palette_ctl (palette_ctl),
        .in_valid    (stage_valid),
        .in_ready    (stage_ready),
        .in_data     (stage_data),
        .out_valid   (pix_out_valid),
        .out_ready   (pix_out_ready),
        .out_data    (pix_out),
        .ram_addr    (pix_ram_addr),
        .ram_en      (pix_ram_en),
        .ram_rdata   (pix_ram_rdata)
    );

endmodule
